/* Makefile */
TOP = control_panel_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f control_panel.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

/* cabinet_pkg.sv */
`include "control_settings.svh"

package cabinet_pkg;

	// all active high, pressed = 1
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
		logic fire_c;
	} player_ctl_t;

	typedef struct packed {
		logic coin1;
		logic coin2;
		logic start1;
		logic start2;
	} sys_ctl_t;

	typedef logic [7:0] port_byte_t; // active low at the cpu

	typedef logic signed [`SPIN_W-1:0] spin_t;

	typedef struct packed {
		logic vertical;
		logic ccw;
		logic four_player;
		logic spinner;
	} variant_t;

endpackage

/* cabinet_ports.sv */
`timescale 1ns/1ps
`include "control_settings.svh"

module cabinet_ports (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  cabinet_pkg::player_ctl_t ply [`NUM_PLAYERS],
	input  cabinet_pkg::sys_ctl_t    sys,
	input  logic                     mouse_button,
	input  cabinet_pkg::spin_t       spin,
	input  cabinet_pkg::variant_t    variant,
	output cabinet_pkg::port_byte_t  inp0,
	output cabinet_pkg::port_byte_t  inp1,
	output cabinet_pkg::port_byte_t  inp2
);

	// pressed-high images of the three ports
	cabinet_pkg::port_byte_t pack0;
	cabinet_pkg::port_byte_t pack1;
	cabinet_pkg::port_byte_t pack2;

	function automatic cabinet_pkg::port_byte_t std_byte(input cabinet_pkg::player_ctl_t p);
		return {p.left, p.right, p.up, p.down, 1'b0, p.fire_b, p.fire_a, p.fire_c};
	endfunction

	function automatic logic [3:0] dirs(input cabinet_pkg::player_ctl_t p);
		return {p.left, p.right, p.up, p.down};
	endfunction

	always_comb begin
		pack0 = std_byte(ply[0]);
		pack1 = std_byte(ply[1]);
		pack2 = {2'b00, sys.start2, sys.start1, 3'b000, sys.coin1};
		if (variant.spinner) begin
			pack0 = spin[`SPIN_W-1:1]; // lsb dropped
			pack1 = spin[`SPIN_W-1:1];
			pack2 = {ply[1].fire_a | mouse_button, ply[0].fire_a | mouse_button,
				sys.start2, sys.start1, 2'b00, sys.coin2, sys.coin1};
		end else if (variant.four_player) begin
			pack0 = {dirs(ply[0]), dirs(ply[1])};
			pack1 = {dirs(ply[2]), dirs(ply[3])};
			pack2 = {ply[2].fire_a | ply[3].fire_a, ply[0].fire_a | ply[1].fire_a,
				sys.start2, sys.start1, 3'b000, sys.coin1};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			inp0 <= 8'hff; // nothing pressed
			inp1 <= 8'hff;
			inp2 <= 8'hff;
		end else begin
			inp0 <= ~pack0;
			inp1 <= ~pack1;
			inp2 <= ~pack2;
		end
	end

endmodule

/* control_latch.sv */
`timescale 1ns/1ps
`include "control_settings.svh"

module control_latch (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	input  host_input_pkg::joy_word_t    joy [`NUM_PLAYERS],
	input  logic                         key_strobe,
	input  logic                         key_pressed,
	input  host_input_pkg::key_code_t    key_code,
	input  host_input_pkg::mouse_flags_t mouse_flags,
	output cabinet_pkg::player_ctl_t     raw_ply [`NUM_PLAYERS],
	output cabinet_pkg::sys_ctl_t        sys,
	output logic                         mouse_button
);

	function automatic cabinet_pkg::player_ctl_t decode_joy(input host_input_pkg::joy_word_t w);
		cabinet_pkg::player_ctl_t p;
		p.up     = w[`JOY_UP];
		p.down   = w[`JOY_DOWN];
		p.left   = w[`JOY_LEFT];
		p.right  = w[`JOY_RIGHT];
		p.fire_a = w[`JOY_FIRE_A];
		p.fire_b = w[`JOY_FIRE_B];
		p.fire_c = w[`JOY_FIRE_C];
		return p;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			for (int p = 0; p < `NUM_PLAYERS; p++) begin
				raw_ply[p] <= '0;
			end
			mouse_button <= 1'b0;
		end else begin
			for (int p = 0; p < `NUM_PLAYERS; p++) begin
				raw_ply[p] <= decode_joy(joy[p]);
			end
			mouse_button <= |mouse_flags; // any button counts
		end
	end

	// held flags, make sets and break clears
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			sys <= '0;
		end else if (key_strobe) begin
			case (key_code)
				`KEY_COIN1:  sys.coin1  <= key_pressed;
				`KEY_COIN2:  sys.coin2  <= key_pressed;
				`KEY_START1: sys.start1 <= key_pressed;
				`KEY_START2: sys.start2 <= key_pressed;
				default:     ; // other keys ignored
			endcase
		end
	end

endmodule

/* control_panel.f */
+incdir+.
host_input_pkg.sv
cabinet_pkg.sv
control_latch.sv
player_orient.sv
spinner_accum.sv
cabinet_ports.sv
control_panel_top.sv
tb_clock_gen.sv
control_panel_asserts.sv
control_panel_tb.sv

/* control_panel_asserts.sv */
`timescale 1ns/1ps
`include "control_settings.svh"

module control_panel_asserts (
	input logic                         clk_sys,
	input logic                         rst_n,
	input logic                         mouse_strobe,
	input host_input_pkg::mouse_delta_t mouse_x,
	input cabinet_pkg::spin_t           spin,
	input cabinet_pkg::port_byte_t      inp0,
	input cabinet_pkg::port_byte_t      inp1,
	input cabinet_pkg::port_byte_t      inp2
);

	int unsigned fail_count = 0; // read by the testbench at the end

	a_reset_idle: assert property (@(posedge clk_sys)
		!rst_n |=> (inp0 == 8'hff && inp1 == 8'hff && inp2 == 8'hff))
		else begin
			fail_count++;
			$error("ports not idle in the cycle after reset");
		end

	// spinner only moves on a mouse step
	a_spin_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!mouse_strobe |=> $stable(spin))
		else begin
			fail_count++;
			$error("spinner changed without a mouse strobe");
		end

	a_spin_no_wrap: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(mouse_strobe && spin[`SPIN_W-1] == mouse_x[`SPIN_W-1])
		|=> spin[`SPIN_W-1] == $past(spin[`SPIN_W-1]))
		else begin
			fail_count++;
			$error("spinner wrapped its sign on a same-sign step");
		end

endmodule

/* control_panel_tb.sv */
`timescale 1ns/1ps
`include "control_settings.svh"

module control_panel_tb;

	typedef struct packed {
		logic [31:0] joys;     // p4, p3, p2, p1
		logic [9:0]  key;      // strobe, pressed, code
		logic [3:0]  steps;
		logic [8:0]  dx;
		logic [2:0]  flags;
		logic        rotate;
		logic [6:0]  core_mod;
		logic [23:0] ports;    // inp0, inp1, inp2
	} row_t;

	localparam int NUM_FIXED = 27;
	localparam int NUM_ROWS = NUM_FIXED + 16;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * 6 + 40;
	localparam logic [9:0] NO_KEY = '0;

	logic                         clk_sys;
	logic                         rst_n;
	host_input_pkg::joy_word_t    joy [`NUM_PLAYERS];
	logic                         key_strobe;
	logic                         key_pressed;
	host_input_pkg::key_code_t    key_code;
	logic                         mouse_strobe;
	host_input_pkg::mouse_delta_t mouse_x;
	host_input_pkg::mouse_flags_t mouse_flags;
	logic                         rotate;
	logic [6:0]                   core_mod;
	cabinet_pkg::port_byte_t      inp0;
	cabinet_pkg::port_byte_t      inp1;
	cabinet_pkg::port_byte_t      inp2;

	row_t rows [NUM_ROWS];
	int   errs [3];
	int   n_checks = 0;

	tb_clock_gen clock_gen_inst (.clk_sys(clk_sys), .rst_n(rst_n));

	control_panel_top control_panel_top_inst (.*);

	bind control_panel_top control_panel_asserts control_panel_asserts_inst (
		.clk_sys(clk_sys), .rst_n(rst_n), .mouse_strobe(mouse_strobe), .mouse_x(mouse_x),
		.spin(spin), .inp0(inp0), .inp1(inp1), .inp2(inp2)
	);

	function automatic logic [9:0] key_make(input logic [7:0] code);
		return {2'b11, code};
	endfunction

	function automatic logic [9:0] key_break(input logic [7:0] code);
		return {2'b10, code};
	endfunction

	// standard layout straight from the joystick word, active low
	function automatic cabinet_pkg::port_byte_t std_port(input host_input_pkg::joy_word_t w);
		return ~{w[`JOY_LEFT], w[`JOY_RIGHT], w[`JOY_UP], w[`JOY_DOWN], 1'b0,
			w[`JOY_FIRE_B], w[`JOY_FIRE_A], w[`JOY_FIRE_C]};
	endfunction

	task automatic check_port(input int idx, input string name,
		input cabinet_pkg::port_byte_t got, input cabinet_pkg::port_byte_t want);
		n_checks++;
		assert (got === want) else begin
			errs[idx]++;
			$display("FAILED %0t %s: got %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic apply_row(input row_t r);
		@(posedge clk_sys);
		#2;
		for (int p = 0; p < `NUM_PLAYERS; p++) begin
			joy[p] = r.joys[p*8 +: 8];
		end
		mouse_flags = r.flags;
		rotate      = r.rotate;
		core_mod    = r.core_mod;
		if (r.key[9]) begin // one key event per row
			key_strobe  = 1'b1;
			key_pressed = r.key[8];
			key_code    = r.key[7:0];
			@(posedge clk_sys);
			#2 key_strobe = 1'b0;
		end
		for (int s = 0; s < int'(r.steps); s++) begin
			mouse_strobe = 1'b1;
			mouse_x      = r.dx;
			@(posedge clk_sys);
			#2;
		end
		mouse_strobe = 1'b0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys); // ports settled
	endtask

	initial begin
		#(WATCHDOG_CYCLES * 40);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

	initial begin
		logic [31:0] j;
		int          total;
		void'($urandom(32'h9d09));
		for (int p = 0; p < `NUM_PLAYERS; p++) begin
			joy[p] = '0;
		end
		key_strobe   = 1'b0;
		key_pressed  = 1'b0;
		key_code     = '0;
		mouse_strobe = 1'b0;
		mouse_x      = '0;
		mouse_flags  = '0;
		rotate       = 1'b0;
		core_mod     = '0;
		errs         = '{0, 0, 0};

		// standard layout, players 1 and 2
		rows[0]  = '{32'h0000_0000, NO_KEY, 4'd0, 9'h000, 3'b000, 1'b0, 7'h00, 24'hff_ff_ff};
		rows[1]  = '{32'h0000_0002, NO_KEY, 4'd0, 9'h000, 3'b000, 1'b0, 7'h00, 24'h7f_ff_ff};
		rows[2]  = '{32'h0000_0001, NO_KEY, 4'd0, 9'h000, 3'b000, 1'b0, 7'h00, 24'hbf_ff_ff};
		rows[3]  = '{32'h0000_0408, NO_KEY, 4'd0, 9'h000, 3'b000, 1'b0, 7'h00, 24'hdf_ef_ff};
		rows[4]  = '{32'h0000_2010, NO_KEY, 4'd0, 9'h000, 3'b000, 1'b0, 7'h00, 24'hfd_fb_ff};
		rows[5]  = '{32'h0000_5040, NO_KEY, 4'd0, 9'h000, 3'b000, 1'b0, 7'h00, 24'hfe_fc_ff};
		// held coin and start keys
		rows[6]  = '{32'h0, key_make(`KEY_COIN1), 4'd0, 9'h000, 3'b000, 1'b0, 7'h00, 24'hff_ff_fe};
		rows[7]  = '{32'h0, key_make(`KEY_START1), 4'd0, 9'h000, 3'b000, 1'b0, 7'h00, 24'hff_ff_ee};
		rows[8]  = '{32'h0, key_make(`KEY_START2), 4'd0, 9'h000, 3'b000, 1'b0, 7'h00, 24'hff_ff_ce};
		rows[9]  = '{32'h0, key_break(8'h1c), 4'd0, 9'h000, 3'b000, 1'b0, 7'h00, 24'hff_ff_ce};
		rows[10] = '{32'h0, key_break(`KEY_COIN1), 4'd0, 9'h000, 3'b000, 1'b0, 7'h00, 24'hff_ff_cf};
		rows[11] = '{32'h0, key_break(`KEY_START1), 4'd0, 9'h000, 3'b000, 1'b0, 7'h00, 24'hff_ff_df};
		rows[12] = '{32'h0, key_break(`KEY_START2), 4'd0, 9'h000, 3'b000, 1'b0, 7'h00, 24'hff_ff_ff};
		// p1 left plus fire_a, rotated cw, ccw, then not rotated
		rows[13] = '{32'h0000_0012, NO_KEY, 4'd0, 9'h000, 3'b000, 1'b1, 7'h02, 24'hdd_ff_ff};
		rows[14] = '{32'h0000_0012, NO_KEY, 4'd0, 9'h000, 3'b000, 1'b1, 7'h12, 24'hed_ff_ff};
		rows[15] = '{32'h0000_0012, NO_KEY, 4'd0, 9'h000, 3'b000, 1'b0, 7'h02, 24'h7d_ff_ff};
		rows[16] = '{32'h0000_0012, NO_KEY, 4'd0, 9'h000, 3'b000, 1'b1, 7'h00, 24'h7d_ff_ff};
		// four players
		rows[17] = '{32'h0401_0802, NO_KEY, 4'd0, 9'h000, 3'b000, 1'b0, 7'h08, 24'h7d_be_ff};
		rows[18] = '{32'h1000_0010, NO_KEY, 4'd0, 9'h000, 3'b000, 1'b0, 7'h08, 24'hff_ff_3f};
		rows[19] = '{32'h0011_1400, NO_KEY, 4'd0, 9'h000, 3'b000, 1'b0, 7'h08, 24'hfe_bf_3f};
		// spinner, 9'h064 is +100 and 9'h19c is -100
		rows[20] = '{32'h0, NO_KEY, 4'd5, 9'h064, 3'b000, 1'b0, 7'h20, 24'h80_80_ff};
		rows[21] = '{32'h0, NO_KEY, 4'd1, 9'h19c, 3'b000, 1'b0, 7'h20, 24'hb2_b2_ff};
		rows[22] = '{32'h0, NO_KEY, 4'd5, 9'h19c, 3'b000, 1'b0, 7'h20, 24'h7f_7f_ff};
		rows[23] = '{32'h0, NO_KEY, 4'd1, 9'h19c, 3'b000, 1'b0, 7'h20, 24'h7f_7f_ff};
		rows[24] = '{32'h0, NO_KEY, 4'd0, 9'h000, 3'b001, 1'b0, 7'h20, 24'h7f_7f_3f};
		rows[25] = '{32'h0, key_make(`KEY_COIN2), 4'd0, 9'h000, 3'b000, 1'b0, 7'h20, 24'h7f_7f_fd};
		rows[26] = '{32'h1000, key_break(`KEY_COIN2), 4'd0, 9'h000, 3'b000, 1'b0, 7'h20,
			24'h7f_7f_7f};
		for (int i = 0; i < 16; i++) begin
			j = $urandom;
			rows[NUM_FIXED + i] = '{j, NO_KEY, 4'd0, 9'h000, 3'b000, 1'b0, 7'h00,
				{std_port(j[7:0]), std_port(j[15:8]), 8'hff}};
		end

		wait (rst_n === 1'b1);
		@(negedge clk_sys);
		check_port(0, "inp0", inp0, 8'hff);
		check_port(1, "inp1", inp1, 8'hff);
		check_port(2, "inp2", inp2, 8'hff);

		foreach (rows[i]) begin
			apply_row(rows[i]);
			check_port(0, "inp0", inp0, rows[i].ports[23:16]);
			check_port(1, "inp1", inp1, rows[i].ports[15:8]);
			check_port(2, "inp2", inp2, rows[i].ports[7:0]);
		end

		total = errs[0] + errs[1] + errs[2]
			+ int'(control_panel_top_inst.control_panel_asserts_inst.fail_count);
		$display("checks %0d, errors inp0 %0d, inp1 %0d, inp2 %0d, assertions %0d",
			n_checks, errs[0], errs[1], errs[2],
			control_panel_top_inst.control_panel_asserts_inst.fail_count);
		if (total == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* control_panel_top.sv */
`timescale 1ns/1ps
`include "control_settings.svh"

module control_panel_top (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	input  host_input_pkg::joy_word_t    joy [`NUM_PLAYERS],
	input  logic                         key_strobe,
	input  logic                         key_pressed,
	input  host_input_pkg::key_code_t    key_code,
	input  logic                         mouse_strobe,
	input  host_input_pkg::mouse_delta_t mouse_x,
	input  host_input_pkg::mouse_flags_t mouse_flags,
	input  logic                         rotate,
	input  logic [6:0]                   core_mod,
	output cabinet_pkg::port_byte_t      inp0,
	output cabinet_pkg::port_byte_t      inp1,
	output cabinet_pkg::port_byte_t      inp2
);

	cabinet_pkg::variant_t    variant;
	cabinet_pkg::player_ctl_t raw_ply [`NUM_PLAYERS];
	cabinet_pkg::player_ctl_t ply [`NUM_PLAYERS];
	cabinet_pkg::sys_ctl_t    sys;
	cabinet_pkg::spin_t       spin;
	logic                     mouse_button;

	// core_mod bits: 1 vertical, 4 ccw, 3 four players, 5 spinner
	assign variant = '{vertical: core_mod[1], ccw: core_mod[4],
		four_player: core_mod[3], spinner: core_mod[5]};

	control_latch control_latch_inst (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.joy          (joy),
		.key_strobe   (key_strobe),
		.key_pressed  (key_pressed),
		.key_code     (key_code),
		.mouse_flags  (mouse_flags),
		.raw_ply      (raw_ply),
		.sys          (sys),
		.mouse_button (mouse_button)
	);

	for (genvar i = 0; i < `NUM_PLAYERS; i++) begin : g_orient
		player_orient player_orient_inst (
			.clk_sys (clk_sys),
			.rst_n   (rst_n),
			.raw     (raw_ply[i]),
			.rotate  (rotate),
			.variant (variant),
			.ply     (ply[i])
		);
	end

	spinner_accum spinner_accum_inst (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.mouse_strobe (mouse_strobe),
		.mouse_x      (mouse_x),
		.spin         (spin)
	);

	cabinet_ports cabinet_ports_inst (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.ply          (ply),
		.sys          (sys),
		.mouse_button (mouse_button),
		.spin         (spin),
		.variant      (variant),
		.inp0         (inp0),
		.inp1         (inp1),
		.inp2         (inp2)
	);

endmodule

/* control_settings.svh */
`ifndef CONTROL_SETTINGS_SVH
`define CONTROL_SETTINGS_SVH

// player slots, port layouts assume four
`define NUM_PLAYERS 4

// bit positions in the host joystick word
`define JOY_RIGHT  0
`define JOY_LEFT   1
`define JOY_DOWN   2
`define JOY_UP     3
`define JOY_FIRE_A 4
`define JOY_FIRE_B 5
`define JOY_FIRE_C 6

// spinner accumulator width, signed
`define SPIN_W 9

// ps/2 set-2 make codes
`define KEY_COIN1  8'h2e // 5
`define KEY_COIN2  8'h36 // 6
`define KEY_START1 8'h16 // 1
`define KEY_START2 8'h1e // 2

`endif

/* host_input_pkg.sv */
package host_input_pkg;

	// one player's joystick word, active high
	typedef logic [7:0] joy_word_t;

	typedef logic [7:0] key_code_t;

	// relative motion, one step per mouse strobe
	typedef logic signed [8:0] mouse_delta_t;

	typedef logic [2:0] mouse_flags_t; // left, right, middle

endpackage

/* player_orient.sv */
`timescale 1ns/1ps

module player_orient (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  cabinet_pkg::player_ctl_t raw,
	input  logic                     rotate,
	input  cabinet_pkg::variant_t    variant,
	output cabinet_pkg::player_ctl_t ply
);

	cabinet_pkg::player_ctl_t turned;

	always_comb begin
		turned = raw; // fire bits never move
		if (rotate && variant.vertical) begin
			if (!variant.ccw) begin
				// monitor turned clockwise
				turned.up    = raw.left;
				turned.right = raw.up;
				turned.down  = raw.right;
				turned.left  = raw.down;
			end else begin
				turned.up    = raw.right;
				turned.left  = raw.up;
				turned.down  = raw.left;
				turned.right = raw.down;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ply <= '0;
		end else begin
			ply <= turned;
		end
	end

endmodule

/* spinner_accum.sv */
`timescale 1ns/1ps
`include "control_settings.svh"

module spinner_accum (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	input  logic                         mouse_strobe,
	input  host_input_pkg::mouse_delta_t mouse_x,
	output cabinet_pkg::spin_t           spin
);

	localparam int MSB = `SPIN_W - 1;

	cabinet_pkg::spin_t sum;
	logic               ovf;

	assign sum = spin + mouse_x; // wraps, caught below
	// only a same-sign step can leave the range
	assign ovf = (spin[MSB] == mouse_x[MSB]) && (sum[MSB] != spin[MSB]);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			spin <= '0;
		end else if (mouse_strobe) begin
			if (ovf)
				spin <= {spin[MSB], {MSB{~spin[MSB]}}}; // +255 or -256
			else
				spin <= sum;
		end
	end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_sys,
	output logic rst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys; // 40 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk_sys);
		#2 rst_n = 1'b1;
	end

endmodule
